/* all.f */
+incdir+.
rv_decode_pkg.sv
rv_register_file.sv
rv_scoreboard.sv
rv_issue_control.sv
rv_decode_top.sv
rv_decode_sva.sv
tb_rv_decode.sv

/* run.sh */
#!/bin/sh
# Build the decode-stage testbench with Verilator and run it.
# Exit status is nonzero when the build fails or the simulation stops on an error.
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert -Wno-fatal \
        --top-module tb_rv_decode -f all.f -o sim_tb_rv_decode \
    && ./obj_dir/sim_tb_rv_decode \
    || exit 1

/* rv_decode_params.svh */
/*
 * Width, credit, exit-code and opcode constants for the RV32I decode stage.
 * Include before use in any package, module or testbench.
 */
`ifndef RV_DECODE_PARAMS_SVH
`define RV_DECODE_PARAMS_SVH

`default_nettype none

// Datapath and register file
`define RV_XLEN            32
`define RV_REG_ADDR_WIDTH  5
`define RV_NUM_REGS        32

// Scoreboard, jump epoch and credit counters
`define RV_STATUS_WIDTH    3
`define RV_JUMP_FLAG_WIDTH 2
`define RV_EXEC_CREDITS    4
`define RV_CREDIT_WIDTH    3

// Exit codes and the register read by EBREAK
`define RV_EXIT_ILLEGAL    8'd1
`define RV_EXIT_MULDIV     8'd3
`define RV_EXIT_REG        5'd10

// Base opcodes
`define RV_OPCODE_OP_IMM   7'b0010011
`define RV_OPCODE_OP       7'b0110011
`define RV_OPCODE_LUI      7'b0110111
`define RV_OPCODE_AUIPC    7'b0010111
`define RV_OPCODE_JAL      7'b1101111
`define RV_OPCODE_JALR     7'b1100111
`define RV_OPCODE_BRANCH   7'b1100011
`define RV_OPCODE_LOAD     7'b0000011
`define RV_OPCODE_STORE    7'b0100011
`define RV_OPCODE_SYSTEM   7'b1110011

// M extension marker and EBREAK immediate
`define RV_FUNCT7_MULDIV   7'd1
`define RV_FUNCT12_EBREAK  12'd1

`default_nettype wire

`endif

/* rv_decode_pkg.sv */
/*
 * Shared vector types and the decode state encoding.
 * Imported by the decode RTL and its testbench.
 */
`include "rv_decode_params.svh"
`default_nettype none

package rv_decode_pkg;

    // Instruction word, register value or program counter
    typedef logic [`RV_XLEN-1:0] rv_word_t;

    // Register index
    typedef logic [`RV_REG_ADDR_WIDTH-1:0] rv_reg_addr_t;

    // Per-register write counter in the scoreboard
    typedef logic [`RV_STATUS_WIDTH-1:0] rv_reg_status_t;

    // Jump epoch tag carried with each instruction
    typedef logic [`RV_JUMP_FLAG_WIDTH-1:0] rv_jump_flag_t;

    // Execute credit count
    typedef logic [`RV_CREDIT_WIDTH-1:0] rv_credit_t;

    // Program exit code
    typedef logic [7:0] rv_exit_code_t;

    // Reset sweep, normal issue, halted
    typedef enum logic [1:0] {
        RV_DECODE_RESET,
        RV_DECODE_NORMAL,
        RV_DECODE_EXIT
    } rv_decode_state_t;

endpackage

`default_nettype wire

/* rv_decode_sva.sv */
/*
 * Concurrent checks on the decode control, bound into rv_issue_control.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module rv_decode_sva (
    input wire logic                              clk,
    input wire logic                              rst_n,
    input wire rv_decode_pkg::rv_decode_state_t   state,
    input wire rv_decode_pkg::rv_credit_t         credits,
    input wire logic                              exec_valid,
    input wire logic                              exit_flag
);
    import rv_decode_pkg::*;

    // Nothing leaves while the register file is being cleared
    no_issue_in_reset: assert property (@(posedge clk) disable iff (!rst_n)
        !(exec_valid && (state == RV_DECODE_RESET)))
        else $error("exec_valid high during the reset sweep");

    // The command was launched from a nonzero credit count
    no_issue_without_credit: assert property (@(posedge clk) disable iff (!rst_n)
        exec_valid |-> ($past(credits) != '0))
        else $error("command issued with zero credits");

    credit_bound: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= rv_credit_t'(`RV_EXEC_CREDITS))
        else $error("credit count above the initial allowance");

    // Only a reset leaves EXIT
    exit_sticky: assert property (@(posedge clk) disable iff (!rst_n)
        $past(exit_flag) |-> exit_flag)
        else $error("exit_flag dropped without a reset");

endmodule

`default_nettype wire

/* rv_decode_top.sv */
/*
 * Decode and issue stage of the RV32I core: control, register file and scoreboard.
 * Fetch feeds it by valid/ready, execute takes commands against credits.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module rv_decode_top (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    input  wire logic                          instr_valid,
    input  wire rv_decode_pkg::rv_word_t       instr_data,
    input  wire rv_decode_pkg::rv_word_t       instr_pc,
    input  wire rv_decode_pkg::rv_jump_flag_t  instr_jump_flag,
    output logic                               instr_ready,

    input  wire logic                          jump_valid,
    input  wire logic                          jump_mispredict,

    input  wire logic                          wb_valid,
    input  wire rv_decode_pkg::rv_reg_addr_t   wb_addr,
    input  wire rv_decode_pkg::rv_word_t       wb_value,

    input  wire logic                          exec_credit_return,
    output logic                               exec_valid,
    output rv_decode_pkg::rv_word_t            exec_instr,
    output rv_decode_pkg::rv_word_t            exec_pc,
    output rv_decode_pkg::rv_word_t            exec_rs1_value,
    output rv_decode_pkg::rv_word_t            exec_rs2_value,
    output rv_decode_pkg::rv_reg_addr_t        exec_rd_addr,
    output rv_decode_pkg::rv_jump_flag_t       exec_jump_flag,
    output logic                               exec_halt,

    output logic                               exit_flag,
    output rv_decode_pkg::rv_exit_code_t       exit_code,
    output rv_decode_pkg::rv_word_t            retired_count
);
    import rv_decode_pkg::*;

    // Register file port
    logic rf_write_en;
    rv_reg_addr_t rf_write_addr;
    rv_word_t rf_write_value;
    rv_reg_addr_t rs1_addr;
    rv_reg_addr_t rs2_addr;
    rv_word_t rs1_value;
    rv_word_t rs2_value;

    // Scoreboard port
    rv_reg_addr_t rd_addr;
    logic rs1_ready;
    logic rs2_ready;
    logic rd_ready;
    logic clear_en;
    rv_reg_addr_t clear_addr;
    logic issue_en;
    rv_reg_addr_t issue_addr;
    logic retire_en;
    rv_reg_addr_t retire_addr;

    rv_issue_control u_control (
        .clk, .rst_n,
        .instr_valid, .instr_data, .instr_pc, .instr_jump_flag, .instr_ready,
        .jump_valid, .jump_mispredict,
        .wb_valid, .wb_addr, .wb_value,
        .exec_credit_return, .exec_valid, .exec_instr, .exec_pc,
        .exec_rs1_value, .exec_rs2_value, .exec_rd_addr, .exec_jump_flag, .exec_halt,
        .exit_flag, .exit_code, .retired_count,
        .rf_write_en, .rf_write_addr, .rf_write_value,
        .rs1_addr, .rs2_addr, .rs1_value, .rs2_value,
        .rd_addr, .rs1_ready, .rs2_ready, .rd_ready,
        .clear_en, .clear_addr, .issue_en, .issue_addr, .retire_en, .retire_addr
    );

    rv_register_file u_register_file (
        .clk,
        .rf_write_en, .rf_write_addr, .rf_write_value,
        .rs1_addr, .rs2_addr, .rs1_value, .rs2_value
    );

    rv_scoreboard u_scoreboard (
        .clk,
        .clear_en, .clear_addr,
        .issue_en, .issue_addr,
        .retire_en, .retire_addr,
        .rs1_addr, .rs2_addr, .rd_addr,
        .rs1_ready, .rs2_ready, .rd_ready
    );

endmodule

`default_nettype wire

/* rv_issue_control.sv */
/*
 * Decode FSM and issue logic: reset sweep, hazard and credit checks, jump flush
 * and exit detection, with one registered command stage toward execute.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module rv_issue_control (
    input  wire logic                          clk,
    input  wire logic                          rst_n,

    // Instruction from fetch
    input  wire logic                          instr_valid,
    input  wire rv_decode_pkg::rv_word_t       instr_data,
    input  wire rv_decode_pkg::rv_word_t       instr_pc,
    input  wire rv_decode_pkg::rv_jump_flag_t  instr_jump_flag,
    output logic                               instr_ready,

    // Branch resolution and writeback
    input  wire logic                          jump_valid,
    input  wire logic                          jump_mispredict,
    input  wire logic                          wb_valid,
    input  wire rv_decode_pkg::rv_reg_addr_t   wb_addr,
    input  wire rv_decode_pkg::rv_word_t       wb_value,

    // Execute command, credit flow control
    input  wire logic                          exec_credit_return,
    output logic                               exec_valid,
    output rv_decode_pkg::rv_word_t            exec_instr,
    output rv_decode_pkg::rv_word_t            exec_pc,
    output rv_decode_pkg::rv_word_t            exec_rs1_value,
    output rv_decode_pkg::rv_word_t            exec_rs2_value,
    output rv_decode_pkg::rv_reg_addr_t        exec_rd_addr,
    output rv_decode_pkg::rv_jump_flag_t       exec_jump_flag,
    output logic                               exec_halt,

    // Status
    output logic                               exit_flag,
    output rv_decode_pkg::rv_exit_code_t       exit_code,
    output rv_decode_pkg::rv_word_t            retired_count,

    // Register file
    output logic                               rf_write_en,
    output rv_decode_pkg::rv_reg_addr_t        rf_write_addr,
    output rv_decode_pkg::rv_word_t            rf_write_value,
    output rv_decode_pkg::rv_reg_addr_t        rs1_addr,
    output rv_decode_pkg::rv_reg_addr_t        rs2_addr,
    input  wire rv_decode_pkg::rv_word_t       rs1_value,
    input  wire rv_decode_pkg::rv_word_t       rs2_value,

    // Scoreboard
    output rv_decode_pkg::rv_reg_addr_t        rd_addr,
    input  wire logic                          rs1_ready,
    input  wire logic                          rs2_ready,
    input  wire logic                          rd_ready,
    output logic                               clear_en,
    output rv_decode_pkg::rv_reg_addr_t        clear_addr,
    output logic                               issue_en,
    output rv_decode_pkg::rv_reg_addr_t        issue_addr,
    output logic                               retire_en,
    output rv_decode_pkg::rv_reg_addr_t        retire_addr
);
    import rv_decode_pkg::*;

    logic [6:0] opcode;
    logic [6:0] funct7;
    logic [11:0] funct12;
    rv_reg_addr_t rd_field;
    rv_reg_addr_t rs1_field;
    rv_reg_addr_t rs2_field;

    rv_decode_state_t state;
    rv_decode_state_t next_state;
    rv_reg_addr_t reset_counter;
    rv_jump_flag_t jump_flag;
    rv_credit_t credits;

    logic in_reset;
    logic flush;
    logic issuable;
    logic issue_fire;
    logic is_illegal;
    logic is_muldiv;
    logic is_ebreak;
    logic writes_rd;
    logic decode_exit;
    logic wb_write;
    rv_exit_code_t next_exit_code;

    // Instruction fields
    assign opcode    = instr_data[6:0];
    assign rd_field  = instr_data[11:7];
    assign rs1_field = instr_data[19:15];
    assign rs2_field = instr_data[24:20];
    assign funct7    = instr_data[31:25];
    assign funct12   = instr_data[31:20];

    always_comb begin
        case (opcode)
            `RV_OPCODE_OP_IMM, `RV_OPCODE_OP, `RV_OPCODE_LUI, `RV_OPCODE_AUIPC,
            `RV_OPCODE_JAL, `RV_OPCODE_JALR, `RV_OPCODE_BRANCH, `RV_OPCODE_LOAD,
            `RV_OPCODE_STORE, `RV_OPCODE_SYSTEM: is_illegal = 1'b0;
            default: is_illegal = 1'b1;
        endcase
    end

    assign is_muldiv = (opcode == `RV_OPCODE_OP) && (funct7 == `RV_FUNCT7_MULDIV);
    assign is_ebreak = (opcode == `RV_OPCODE_SYSTEM) && (funct12 == `RV_FUNCT12_EBREAK);
    assign decode_exit = is_illegal || is_muldiv || is_ebreak;
    assign writes_rd = (opcode != `RV_OPCODE_BRANCH) && (opcode != `RV_OPCODE_STORE) &&
                       (opcode != `RV_OPCODE_SYSTEM);

    always_comb begin
        if (is_illegal) begin
            next_exit_code = `RV_EXIT_ILLEGAL;
        end else if (is_muldiv) begin
            next_exit_code = `RV_EXIT_MULDIV;
        end else begin
            // EBREAK returns the low byte of x10
            next_exit_code = rs1_value[7:0];
        end
    end

    // Operand lookup, EBREAK reads the exit register instead of rs1
    assign rs1_addr = is_ebreak ? `RV_EXIT_REG : rs1_field;
    assign rs2_addr = rs2_field;
    assign rd_addr  = rd_field;

    // Handshake
    assign in_reset = (state == RV_DECODE_RESET);
    assign flush = (instr_jump_flag != jump_flag);
    assign issuable = rs1_ready && rs2_ready && rd_ready && (credits != '0);

    always_comb begin
        case (state)
            RV_DECODE_NORMAL: instr_ready = flush || issuable;
            RV_DECODE_EXIT:   instr_ready = 1'b1;
            default:          instr_ready = 1'b0;
        endcase
    end

    // Consumed, not flushed and not halted
    assign issue_fire = instr_valid && instr_ready && (state == RV_DECODE_NORMAL) && !flush;

    always_comb begin
        next_state = state;
        case (state)
            RV_DECODE_RESET: begin
                if (reset_counter == rv_reg_addr_t'(`RV_NUM_REGS - 1)) begin
                    next_state = RV_DECODE_NORMAL;
                end
            end
            RV_DECODE_NORMAL: begin
                if (issue_fire && decode_exit) begin
                    next_state = RV_DECODE_EXIT;
                end
            end
            default: next_state = state;
        endcase
    end

    // Scoreboard bookkeeping
    assign issue_en   = issue_fire && writes_rd && !decode_exit && (rd_field != '0);
    assign issue_addr = rd_field;
    assign wb_write   = wb_valid && (wb_addr != '0);
    assign retire_en  = wb_write && !in_reset;
    assign retire_addr = wb_addr;
    assign clear_en   = in_reset;
    assign clear_addr = reset_counter;

    // Sweep writes zeros, then the port belongs to writebacks
    assign rf_write_en    = in_reset || wb_write;
    assign rf_write_addr  = in_reset ? reset_counter : wb_addr;
    assign rf_write_value = in_reset ? '0 : wb_value;

    assign exit_flag = (state == RV_DECODE_EXIT);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state         <= RV_DECODE_RESET;
            reset_counter <= '0;
            jump_flag     <= '0;
            credits       <= rv_credit_t'(`RV_EXEC_CREDITS);
            exec_valid    <= 1'b0;
            exit_code     <= '0;
            retired_count <= '0;
        end else begin
            state <= next_state;
            if (in_reset) begin
                reset_counter <= reset_counter + 1'b1;
            end
            // New epoch on a mispredict
            if (jump_valid && jump_mispredict) begin
                jump_flag <= jump_flag + 1'b1;
            end
            // Credit taken at the consuming edge, returned by execute
            credits <= credits - rv_credit_t'(issue_fire) + rv_credit_t'(exec_credit_return);
            exec_valid <= issue_fire;
            if (issue_fire) begin
                retired_count <= retired_count + 1'b1;
            end
            if (issue_fire && decode_exit) begin
                exit_code <= next_exit_code;
            end
        end
    end

    // Command payload, qualified by exec_valid
    always_ff @(posedge clk) begin
        if (issue_fire) begin
            exec_instr     <= instr_data;
            exec_pc        <= instr_pc;
            exec_rs1_value <= rs1_value;
            exec_rs2_value <= rs2_value;
            exec_rd_addr   <= writes_rd ? rd_field : '0;
            exec_jump_flag <= jump_flag;
            exec_halt      <= decode_exit;
        end
    end

endmodule

`default_nettype wire

/* rv_register_file.sv */
/*
 * 32-entry integer register file, one write port and two combinational reads.
 * Cleared by the decode reset sweep, no reset of its own.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module rv_register_file (
    input  wire logic                         clk,

    // Write port
    input  wire logic                         rf_write_en,
    input  wire rv_decode_pkg::rv_reg_addr_t  rf_write_addr,
    input  wire rv_decode_pkg::rv_word_t      rf_write_value,

    // Read ports
    input  wire rv_decode_pkg::rv_reg_addr_t  rs1_addr,
    input  wire rv_decode_pkg::rv_reg_addr_t  rs2_addr,
    output rv_decode_pkg::rv_word_t           rs1_value,
    output rv_decode_pkg::rv_word_t           rs2_value
);
    import rv_decode_pkg::*;

    rv_word_t regs [`RV_NUM_REGS];

    // x0 is never written outside the sweep, so it reads back as zero
    always_ff @(posedge clk) begin
        if (rf_write_en) begin
            regs[rf_write_addr] <= rf_write_value;
        end
    end

    // No bypass, a write is seen from the next cycle
    assign rs1_value = regs[rs1_addr];
    assign rs2_value = regs[rs2_addr];

endmodule

`default_nettype wire

/* rv_scoreboard.sv */
/*
 * Front/rear write counters per register, one pair per architectural register.
 * Front counts issued writers, rear counts writebacks; equal means no write pending.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module rv_scoreboard (
    input  wire logic                         clk,

    // Reset sweep
    input  wire logic                         clear_en,
    input  wire rv_decode_pkg::rv_reg_addr_t  clear_addr,

    // Writer issued by decode
    input  wire logic                         issue_en,
    input  wire rv_decode_pkg::rv_reg_addr_t  issue_addr,

    // Writeback from the back end
    input  wire logic                         retire_en,
    input  wire rv_decode_pkg::rv_reg_addr_t  retire_addr,

    // Operands of the instruction at decode
    input  wire rv_decode_pkg::rv_reg_addr_t  rs1_addr,
    input  wire rv_decode_pkg::rv_reg_addr_t  rs2_addr,
    input  wire rv_decode_pkg::rv_reg_addr_t  rd_addr,
    output logic                              rs1_ready,
    output logic                              rs2_ready,
    output logic                              rd_ready
);
    import rv_decode_pkg::*;

    // Largest number of writes that may be outstanding per register
    localparam rv_reg_status_t STATUS_MAX = '1;

    rv_reg_status_t front [`RV_NUM_REGS];
    rv_reg_status_t rear [`RV_NUM_REGS];
    rv_reg_status_t rd_pending;

    // Clear comes last so the sweep wins over any stray update
    always_ff @(posedge clk) begin
        if (issue_en) begin
            front[issue_addr] <= front[issue_addr] + 1'b1;
        end
        if (clear_en) begin
            front[clear_addr] <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (retire_en) begin
            rear[retire_addr] <= rear[retire_addr] + 1'b1;
        end
        if (clear_en) begin
            rear[clear_addr] <= '0;
        end
    end

    // Sources need every pending write to have landed
    assign rs1_ready = (front[rs1_addr] == rear[rs1_addr]);
    assign rs2_ready = (front[rs2_addr] == rear[rs2_addr]);

    // Modular difference, kept below max so the front never laps the rear
    assign rd_pending = front[rd_addr] - rear[rd_addr];
    assign rd_ready = (rd_pending < STATUS_MAX);

endmodule

`default_nettype wire

/* tb_rv_decode.sv */
/*
 * Directed testbench for the RV32I decode and issue stage.
 * Acts as fetch, writeback and execute around rv_decode_top, one task per behavior.
 */
`timescale 1ns/1ps
`include "rv_decode_params.svh"
`default_nettype none

module tb_rv_decode;
    import rv_decode_pkg::*;

    localparam int MAX_WAIT = 64;

    logic clk;
    logic rst_n;
    logic instr_valid;
    rv_word_t instr_data;
    rv_word_t instr_pc;
    rv_jump_flag_t instr_jump_flag;
    logic instr_ready;
    logic jump_valid;
    logic jump_mispredict;
    logic wb_valid;
    rv_reg_addr_t wb_addr;
    rv_word_t wb_value;
    logic exec_credit_return;
    logic exec_valid;
    rv_word_t exec_instr;
    rv_word_t exec_pc;
    rv_word_t exec_rs1_value;
    rv_word_t exec_rs2_value;
    rv_reg_addr_t exec_rd_addr;
    rv_jump_flag_t exec_jump_flag;
    logic exec_halt;
    logic exit_flag;
    rv_exit_code_t exit_code;
    rv_word_t retired_count;

    // Expected register contents and jump epoch
    rv_word_t reg_model [`RV_NUM_REGS];
    rv_jump_flag_t flag_model;
    logic [31:0] lcg_state;

    rv_decode_top u_dut (
        .clk, .rst_n,
        .instr_valid, .instr_data, .instr_pc, .instr_jump_flag, .instr_ready,
        .jump_valid, .jump_mispredict,
        .wb_valid, .wb_addr, .wb_value,
        .exec_credit_return, .exec_valid, .exec_instr, .exec_pc,
        .exec_rs1_value, .exec_rs2_value, .exec_rd_addr, .exec_jump_flag, .exec_halt,
        .exit_flag, .exit_code, .retired_count
    );

    bind rv_issue_control rv_decode_sva u_sva (
        .clk(clk), .rst_n(rst_n), .state(state), .credits(credits),
        .exec_valid(exec_valid), .exit_flag(exit_flag)
    );

    always #2 clk = ~clk;

    function automatic rv_word_t encode_r(input logic [6:0] funct7, input rv_reg_addr_t rs2,
                                          input rv_reg_addr_t rs1, input rv_reg_addr_t rd,
                                          input logic [6:0] opcode);
        return {funct7, rs2, rs1, 3'b000, rd, opcode};
    endfunction

    function automatic rv_word_t encode_i(input logic [11:0] imm, input rv_reg_addr_t rs1,
                                          input rv_reg_addr_t rd, input logic [6:0] opcode);
        return {imm, rs1, 3'b000, rd, opcode};
    endfunction

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            $display("Mismatch at %0t ns: %s = %0h, expected %0h", $time, name, actual,
                     expected);
            $display("Errors found");
            $fatal(1);
        end
    endtask

    task automatic report_failure(input string what);
        $display("Failure at %0t ns: %s", $time, what);
        $display("Errors found");
        $fatal(1);
    endtask

    // Inputs change 1 ns after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    task automatic drive_idle();
        instr_valid = 1'b0;
        instr_data = '0;
        instr_pc = '0;
        instr_jump_flag = '0;
        jump_valid = 1'b0;
        jump_mispredict = 1'b0;
        wb_valid = 1'b0;
        wb_addr = '0;
        wb_value = '0;
        exec_credit_return = 1'b0;
    endtask

    task automatic present_instr(input rv_word_t data, input rv_word_t pc,
                                 input rv_jump_flag_t flag);
        instr_valid = 1'b1;
        instr_data = data;
        instr_pc = pc;
        instr_jump_flag = flag;
    endtask

    // Returns one cycle after the consuming edge, where a command would show
    task automatic push_instr(input rv_word_t data, input rv_word_t pc,
                              input rv_jump_flag_t flag);
        int waited;
        logic accepted;
        waited = 0;
        accepted = 1'b0;
        present_instr(data, pc, flag);
        while (!accepted) begin
            #1;
            accepted = instr_ready;
            next_cycle();
            waited++;
            if (!accepted && waited > MAX_WAIT) begin
                report_failure("instruction never accepted, instr_ready stayed low");
            end
        end
        instr_valid = 1'b0;
    endtask

    task automatic reset_and_sweep();
        rst_n = 1'b0;
        drive_idle();
        repeat (10) next_cycle();
        rst_n = 1'b1;
        // A ready ADD is offered all through the sweep
        present_instr(encode_r(7'd0, 5'd2, 5'd1, 5'd0, `RV_OPCODE_OP), '0, '0);
        for (int i = 0; i < `RV_NUM_REGS; i++) begin
            #1;
            check_value("instr_ready", instr_ready, 0);
            check_value("exec_valid", exec_valid, 0);
            check_value("exit_flag", exit_flag, 0);
            next_cycle();
        end
        instr_valid = 1'b0;
        check_value("retired_count", retired_count, 0);
        check_value("exit_code", exit_code, 0);
        foreach (reg_model[i]) reg_model[i] = '0;
        flag_model = '0;
    endtask

    task automatic expect_command(input rv_word_t data, input rv_word_t pc, input rv_word_t rs1v,
                                  input rv_word_t rs2v, input rv_reg_addr_t rd, input logic halt);
        check_value("exec_valid", exec_valid, 1);
        check_value("exec_instr", exec_instr, data);
        check_value("exec_pc", exec_pc, pc);
        check_value("exec_rs1_value", exec_rs1_value, rs1v);
        check_value("exec_rs2_value", exec_rs2_value, rs2v);
        check_value("exec_rd_addr", exec_rd_addr, rd);
        check_value("exec_jump_flag", exec_jump_flag, flag_model);
        check_value("exec_halt", exec_halt, halt);
    endtask

    task automatic return_credits(input int count);
        exec_credit_return = 1'b1;
        repeat (count) next_cycle();
        exec_credit_return = 1'b0;
    endtask

    // Issue, check the command and hand its credit straight back
    task automatic issue_checked(input rv_word_t data, input rv_word_t pc, input rv_word_t rs1v,
                                 input rv_word_t rs2v, input rv_reg_addr_t rd);
        push_instr(data, pc, flag_model);
        expect_command(data, pc, rs1v, rs2v, rd, 1'b0);
        return_credits(1);
        check_value("exec_valid", exec_valid, 0);
    endtask

    // Outstanding writer, so the writeback that follows balances the scoreboard
    task automatic claim_register(input rv_reg_addr_t addr, input rv_word_t pc);
        issue_checked(encode_i(12'd0, 5'd0, addr, `RV_OPCODE_OP_IMM), pc, '0, '0, addr);
    endtask

    task automatic write_back(input rv_reg_addr_t addr, input rv_word_t value);
        wb_valid = 1'b1;
        wb_addr = addr;
        wb_value = value;
        next_cycle();
        wb_valid = 1'b0;
        if (addr != '0) begin
            reg_model[addr] = value;
        end
    endtask

    // The presented instruction must sit unconsumed with no command out
    task automatic hold_stalled(input int cycles);
        for (int i = 0; i < cycles; i++) begin
            #1;
            check_value("instr_ready", instr_ready, 0);
            next_cycle();
            check_value("exec_valid", exec_valid, 0);
        end
    endtask

    task automatic jump_notice(input logic mispredict);
        jump_valid = 1'b1;
        jump_mispredict = mispredict;
        next_cycle();
        jump_valid = 1'b0;
        jump_mispredict = 1'b0;
        if (mispredict) begin
            flag_model = flag_model + 1'b1;
        end
    endtask

    task automatic expect_exit(input rv_exit_code_t code);
        check_value("exec_valid", exec_valid, 1);
        check_value("exec_halt", exec_halt, 1);
        check_value("exit_flag", exit_flag, 1);
        check_value("exit_code", exit_code, code);
    endtask

    task automatic test_reset_sweep();
        reset_and_sweep();
        issue_checked(encode_r(7'd0, 5'd2, 5'd1, 5'd0, `RV_OPCODE_OP), 32'h0, '0, '0, 5'd0);
    endtask

    task automatic test_writeback_read();
        claim_register(5'd5, 32'h0fc);
        claim_register(5'd7, 32'h100);
        write_back(5'd5, lcg_next());
        write_back(5'd7, lcg_next());
        issue_checked(encode_r(7'd0, 5'd7, 5'd5, 5'd8, `RV_OPCODE_OP), 32'h104,
                      reg_model[5], reg_model[7], 5'd8);
        write_back(5'd8, reg_model[5] + reg_model[7]);
    endtask

    task automatic test_scoreboard_hazard();
        rv_word_t consumer;
        consumer = encode_r(7'd0, 5'd7, 5'd6, 5'd9, `RV_OPCODE_OP);
        issue_checked(encode_r(7'd0, 5'd0, 5'd0, 5'd6, `RV_OPCODE_OP), 32'h108, '0, '0, 5'd6);
        present_instr(consumer, 32'h10c, flag_model);
        hold_stalled(6);
        write_back(5'd6, lcg_next());
        issue_checked(consumer, 32'h10c, reg_model[6], reg_model[7], 5'd9);
        write_back(5'd9, lcg_next());
    endtask

    task automatic test_credits();
        rv_word_t data;
        // rd is x0 so only the credits can stall these
        for (int k = 0; k < `RV_EXEC_CREDITS; k++) begin
            data = encode_i(12'(k), 5'd0, 5'd0, `RV_OPCODE_OP_IMM);
            present_instr(data, 32'h200 + 32'(4 * k), flag_model);
            #1;
            check_value("instr_ready", instr_ready, 1);
            push_instr(data, 32'h200 + 32'(4 * k), flag_model);
            expect_command(data, 32'h200 + 32'(4 * k), '0, reg_model[k], 5'd0, 1'b0);
        end
        data = encode_i(12'd1, 5'd0, 5'd0, `RV_OPCODE_OP_IMM);
        present_instr(data, 32'h210, flag_model);
        hold_stalled(5);
        return_credits(1);
        push_instr(data, 32'h210, flag_model);
        expect_command(data, 32'h210, '0, reg_model[1], 5'd0, 1'b0);
        present_instr(encode_i(12'd2, 5'd0, 5'd0, `RV_OPCODE_OP_IMM), 32'h214, flag_model);
        hold_stalled(4);
        instr_valid = 1'b0;
        return_credits(`RV_EXEC_CREDITS);
    endtask

    task automatic test_jump_flush();
        rv_word_t count_before;
        rv_word_t data;
        data = encode_r(7'd0, 5'd2, 5'd1, 5'd0, `RV_OPCODE_OP);
        count_before = retired_count;
        jump_notice(1'b1);
        push_instr(data, 32'h300, flag_model - 1'b1);
        check_value("exec_valid", exec_valid, 0);
        check_value("retired_count", retired_count, count_before);
        jump_notice(1'b1);
        // A correct prediction leaves the epoch alone
        jump_notice(1'b0);
        for (int k = 1; k <= 2; k++) begin
            issue_checked(data, 32'h300 + 32'(4 * k), reg_model[1], reg_model[2], 5'd0);
            check_value("retired_count", retired_count, count_before + 32'(k));
        end
    endtask

    task automatic test_exit();
        rv_word_t ebreak;
        rv_word_t muldiv;
        rv_word_t count_after;
        ebreak = encode_i(12'd1, 5'd0, 5'd0, `RV_OPCODE_SYSTEM);
        claim_register(5'd10, 32'h3fc);
        write_back(5'd10, lcg_next() & 32'hff);
        push_instr(ebreak, 32'h400, flag_model);
        expect_command(ebreak, 32'h400, reg_model[10], reg_model[1], 5'd0, 1'b1);
        expect_exit(reg_model[10][7:0]);
        count_after = retired_count;
        push_instr(encode_r(7'd0, 5'd2, 5'd1, 5'd3, `RV_OPCODE_OP), 32'h404, flag_model);
        check_value("exec_valid", exec_valid, 0);
        next_cycle();
        check_value("exec_valid", exec_valid, 0);
        check_value("retired_count", retired_count, count_after);

        reset_and_sweep();
        // x5 and x7 held LCG values before this reset
        muldiv = encode_r(`RV_FUNCT7_MULDIV, 5'd7, 5'd5, 5'd0, `RV_OPCODE_OP);
        push_instr(muldiv, '0, '0);
        expect_command(muldiv, '0, reg_model[5], reg_model[7], 5'd0, 1'b1);
        expect_exit(`RV_EXIT_MULDIV);

        reset_and_sweep();
        push_instr(32'h0000007f, '0, '0);
        expect_exit(`RV_EXIT_ILLEGAL);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        lcg_state = 32'd80;
        flag_model = '0;
        drive_idle();
        test_reset_sweep();
        test_writeback_read();
        test_scoreboard_hazard();
        test_credits();
        test_jump_flush();
        test_exit();
        $display("No errors");
        $finish;
    end

endmodule

`default_nettype wire
